/* Makefile */
SOURCES = $(wildcard rtl/*.sv bench/*.sv)

.PHONY: run clean

run: obj_dir/Vhsid_tb
	./obj_dir/Vhsid_tb

obj_dir/Vhsid_tb: files.f $(SOURCES)
	verilator --binary --timing --assert --top-module hsid_tb -Mdir obj_dir -f files.f

clean:
	rm -rf obj_dir

/* bench/hsid_tb.sv */
module hsid_tb import hsid_pkg::*; ();

  localparam int AW        = 10;
  localparam int MEM_WORDS = 1 << AW;
  localparam int CAPT_BASE = 'h40;
  localparam int LIB_BASE  = 'h100;
  // Captured words plus library words of the three runs that fetch
  localparam int TOTAL_WORDS  = (8 + 20 * 8) + (8 + 6 * 8) + (32 + 3 * 32);
  localparam int LIMIT_CYCLES = TOTAL_WORDS * 4 + 2000;

  typedef struct packed {
    logic [31:0] status;
    extremes_t   ext;
  } snap_t;

  logic        clk = 1'b0;
  logic        reset_i;
  reg_req_t    reg_req_i;
  reg_rsp_t    reg_rsp_o;
  mem_req_t    mem_req_o;
  pixel_word_t mem_rdata_i = '0;
  pixel_word_t rd_pend = '0;       // Word answered at the next falling edge
  logic        irq_o;
  pixel_word_t mem [MEM_WORDS];
  logic [31:0] lfsr = 32'hc169_7c78;
  int          req_count = 0;
  int          irq_count = 0;
  int          n_snaps = 0;
  int          n_compared = 0;
  snap_t       got_q [$];
  snap_t       exp_q [$];
  snap_t       got_s;
  snap_t       exp_s;

  hsid_top #(.MAX_BANDS(64)) dut (
    .clk         (clk),
    .reset_i     (reset_i),
    .reg_req_i   (reg_req_i),
    .reg_rsp_o   (reg_rsp_o),
    .mem_req_o   (mem_req_o),
    .mem_rdata_i (mem_rdata_i),
    .irq_o       (irq_o)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_sse(input string name, input sse_t got, input sse_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  // Galois form, one shift per bit
  function automatic logic lfsr_step();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic band_t rand_band();
    band_t v;
    v = '0;
    for (int i = 0; i < 16; i++) begin
      v = {v[14:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic extremes_t cleared_extremes();
    extremes_t e;
    e.min_val = '1;
    e.min_ref = '0;
    e.max_val = '0;
    e.max_ref = '0;
    return e;
  endfunction

  // Squared band distance of every library pixel, then strict min and max
  function automatic extremes_t ref_extremes(input int bands, input int lib_size);
    extremes_t   e;
    sse_t        d;
    sse_t        df;
    band_t       c;
    band_t       l;
    pixel_word_t cw;
    pixel_word_t lw;
    e = cleared_extremes();
    for (int p = 0; p < lib_size; p++) begin
      d = '0;
      for (int b = 0; b < bands; b++) begin
        cw = mem[AW'(CAPT_BASE + b / 2)];
        lw = mem[AW'(LIB_BASE + p * (bands / 2) + b / 2)];
        c  = (b % 2 == 0) ? cw.bands.band_lo : cw.bands.band_hi;  // Even band in the low half
        l  = (b % 2 == 0) ? lw.bands.band_lo : lw.bands.band_hi;
        df = (c > l) ? sse_t'(c - l) : sse_t'(l - c);
        d  = d + df * df;
      end
      if (d < e.min_val) begin
        e.min_val = d;
        e.min_ref = PIX_W'(p);
      end
      if (d > e.max_val) begin
        e.max_val = d;
        e.max_ref = PIX_W'(p);
      end
    end
    return e;
  endfunction

  task automatic fill_pixel(input int base, input int bands, input band_t keep, input band_t set);
    pixel_word_t w;
    for (int i = 0; i < bands / 2; i++) begin
      w.bands.band_lo = (rand_band() & keep) | set;
      w.bands.band_hi = (rand_band() & keep) | set;
      mem[AW'(base + i)] = w;
    end
  endtask

  task automatic copy_pixel(input int dst, input int src, input int bands);
    for (int i = 0; i < bands / 2; i++) begin
      mem[AW'(dst + i)] = mem[AW'(src + i)];
    end
  endtask

  task automatic reg_access(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    reg_req_i.valid = 1'b1;
    reg_req_i.write = write;
    reg_req_i.addr  = addr;
    reg_req_i.wdata = wdata;
    @(negedge clk);
    reg_req_i = '0;
    if (!reg_rsp_o.valid) begin
      abort_run("A register access got no response one cycle later");
    end else begin
      rdata = reg_rsp_o.rdata;
    end
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    reg_access(1'b1, addr, data, rd);
    check_word("reg_rsp_o.rdata", rd, '0);  // Writes answer with zero
  endtask

  task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
    reg_access(1'b0, addr, '0, data);
  endtask

  task automatic configure(input int bands, input int lib_size);
    reg_write(REG_BANDS, bands);
    reg_write(REG_LIB_SIZE, lib_size);
    reg_write(REG_CAPT_ADDR, CAPT_BASE);
    reg_write(REG_LIB_ADDR, LIB_BASE);
  endtask

  task automatic run_to_irq();
    reg_write(REG_CTRL, 32'h1);
    do begin
      @(negedge clk);
    end while (!irq_o);
  endtask

  // Reads status and extremes, queued for the compare process
  task automatic snapshot(input logic [31:0] status, input extremes_t ext);
    snap_t       s;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] r;
    exp_q.push_back({status, ext});
    n_snaps++;
    reg_read(REG_STATUS, s.status);
    reg_read(REG_MIN_LO, lo);
    reg_read(REG_MIN_HI, hi);
    s.ext.min_val = {hi[15:0], lo};
    reg_read(REG_MIN_REF, r);
    s.ext.min_ref = r[PIX_W-1:0];
    reg_read(REG_MAX_LO, lo);
    reg_read(REG_MAX_HI, hi);
    s.ext.max_val = {hi[15:0], lo};
    reg_read(REG_MAX_REF, r);
    s.ext.max_ref = r[PIX_W-1:0];
    got_q.push_back(s);
  endtask

  // Memory answers each strobe one cycle later
  always @(negedge clk) begin
    mem_rdata_i = rd_pend;
    if (mem_req_o.valid && mem_req_o.addr >= MEM_WORDS) begin
      abort_run("The DUT read a memory address outside the model");
    end else if (mem_req_o.valid) begin
      rd_pend = mem[mem_req_o.addr[AW-1:0]];
      req_count++;
    end else begin
      rd_pend = '0;
    end
  end

  always @(posedge clk) begin
    if (irq_o) begin
      irq_count++;
    end
  end

  always @(negedge clk) begin
    if (got_q.size() != 0) begin
      got_s = got_q.pop_front();
      exp_s = exp_q.pop_front();
      check_word("status", got_s.status, exp_s.status);
      check_sse("min_val", got_s.ext.min_val, exp_s.ext.min_val);
      check_word("min_ref", 32'(got_s.ext.min_ref), 32'(exp_s.ext.min_ref));
      check_sse("max_val", got_s.ext.max_val, exp_s.ext.max_val);
      check_word("max_ref", 32'(got_s.ext.max_ref), 32'(exp_s.ext.max_ref));
      n_compared++;
    end
  end

  initial begin
    #(LIMIT_CYCLES * 100);
    abort_run("Timeout, the test sequence did not finish within the cycle limit");
  end

  initial begin
    extremes_t e_prev;
    int        req_before;
    reset_i   = 1'b1;
    reg_req_i = '0;
    repeat (5) @(negedge clk);
    reset_i = 1'b0;

    snapshot(32'h1, cleared_extremes());  // Idle, nothing done

    fill_pixel(CAPT_BASE, 16, 16'hffff, 16'h0000);
    for (int p = 0; p < 20; p++) begin
      fill_pixel(LIB_BASE + p * 8, 16, 16'hffff, 16'h0000);
    end
    configure(16, 20);
    run_to_irq();
    snapshot(32'h3, ref_extremes(16, 20));
    check_word("irq_count", irq_count, 1);

    reg_write(REG_CTRL, 32'h2);
    fill_pixel(CAPT_BASE, 16, 16'hffff, 16'h0000);
    for (int p = 0; p < 6; p++) begin
      fill_pixel(LIB_BASE + p * 8, 16, 16'hffff, 16'h0000);
    end
    copy_pixel(LIB_BASE + 2 * 8, CAPT_BASE, 16);  // Two exact matches, index 2 wins
    copy_pixel(LIB_BASE + 4 * 8, CAPT_BASE, 16);
    configure(16, 6);
    run_to_irq();
    e_prev = ref_extremes(16, 6);
    snapshot(32'h3, e_prev);
    check_word("irq_count", irq_count, 2);

    // Rejected starts keep idle and the old extremes
    req_before = req_count;
    configure(15, 6);
    reg_write(REG_CTRL, 32'h1);
    snapshot(32'h7, e_prev);
    // Clear drops done, error and the extremes before each further reject
    reg_write(REG_CTRL, 32'h2);
    configure(66, 6);
    reg_write(REG_CTRL, 32'h1);
    snapshot(32'h5, cleared_extremes());
    reg_write(REG_CTRL, 32'h2);
    configure(16, 0);
    reg_write(REG_CTRL, 32'h1);
    snapshot(32'h5, cleared_extremes());
    check_word("mem_req_count", req_count, req_before);
    check_word("irq_count", irq_count, 2);

    reg_write(REG_CTRL, 32'h2);
    snapshot(32'h1, cleared_extremes());
    fill_pixel(CAPT_BASE, 64, 16'h000f, 16'h0000);
    for (int p = 0; p < 3; p++) begin
      fill_pixel(LIB_BASE + p * 32, 64, 16'h000f, 16'hfff0);  // Sums pass 32 bits
    end
    configure(64, 3);
    run_to_irq();
    snapshot(32'h3, ref_extremes(64, 3));
    check_word("irq_count", irq_count, 3);

    wait (n_compared == n_snaps);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* files.f */
rtl/hsid_pkg.sv
rtl/hsid_ctrl_reg.sv
rtl/hsid_fetch_seq.sv
rtl/hsid_dist_unit.sv
rtl/hsid_extreme_trk.sv
rtl/hsid_top.sv
bench/hsid_tb.sv

/* rtl/hsid_ctrl_reg.sv */
module hsid_ctrl_reg import hsid_pkg::*; #(
  parameter int MAX_BANDS = 64
) (
  input  logic      clk,
  input  logic      reset_i,
  input  reg_req_t  reg_req_i,
  output reg_rsp_t  reg_rsp_o,
  input  extremes_t extremes_i,
  input  logic      run_done_i,
  output cfg_t      cfg_o,
  output logic      run_start_o,
  output logic      clear_o
);

  logic              idle_q;
  logic              done_q;
  logic              error_q;
  logic              cfg_ok;
  logic [WORD_W-1:0] rd_data;

  // Band count must be even, nonzero and fit the captured buffer
  assign cfg_ok = (cfg_o.bands != '0) && !cfg_o.bands[0] &&
                  (int'(cfg_o.bands) <= MAX_BANDS) && (cfg_o.lib_size != '0);

  always_comb begin
    rd_data = '0;
    case (reg_req_i.addr)
      REG_STATUS:    rd_data = {29'd0, error_q, done_q, idle_q};
      REG_BANDS:     rd_data = {24'd0, cfg_o.bands};
      REG_LIB_SIZE:  rd_data = {20'd0, cfg_o.lib_size};
      REG_CAPT_ADDR: rd_data = cfg_o.capt_addr;
      REG_LIB_ADDR:  rd_data = cfg_o.lib_addr;
      REG_MIN_LO:    rd_data = extremes_i.min_val[31:0];
      REG_MIN_HI:    rd_data = {16'd0, extremes_i.min_val[47:32]};
      REG_MIN_REF:   rd_data = {20'd0, extremes_i.min_ref};
      REG_MAX_LO:    rd_data = extremes_i.max_val[31:0];
      REG_MAX_HI:    rd_data = {16'd0, extremes_i.max_val[47:32]};
      REG_MAX_REF:   rd_data = {20'd0, extremes_i.max_ref};
      default:       rd_data = '0;  // CTRL reads back as zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      cfg_o       <= '0;
      idle_q      <= 1'b1;
      done_q      <= 1'b0;
      error_q     <= 1'b0;
      run_start_o <= 1'b0;
      clear_o     <= 1'b0;
      reg_rsp_o   <= '0;
    end else begin
      run_start_o     <= 1'b0;
      clear_o         <= 1'b0;
      reg_rsp_o.valid <= reg_req_i.valid;
      reg_rsp_o.rdata <= (reg_req_i.valid && !reg_req_i.write) ? rd_data : '0;

      if (run_done_i) begin
        done_q <= 1'b1;
        idle_q <= 1'b1;
      end

      if (reg_req_i.valid && reg_req_i.write) begin
        case (reg_req_i.addr)
          REG_CTRL: begin
            if (reg_req_i.wdata[1]) begin  // Clear
              clear_o <= 1'b1;
              done_q  <= 1'b0;
              error_q <= 1'b0;
            end
            if (reg_req_i.wdata[0]) begin  // Start, only with a sane config
              if (idle_q && cfg_ok) begin
                run_start_o <= 1'b1;
                idle_q      <= 1'b0;
                done_q      <= 1'b0;
                error_q     <= 1'b0;
              end else begin
                error_q <= 1'b1;
              end
            end
          end
          REG_BANDS:     cfg_o.bands     <= reg_req_i.wdata[7:0];
          REG_LIB_SIZE:  cfg_o.lib_size  <= reg_req_i.wdata[PIX_W-1:0];
          REG_CAPT_ADDR: cfg_o.capt_addr <= reg_req_i.wdata;
          REG_LIB_ADDR:  cfg_o.lib_addr  <= reg_req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  // A run only ends while one is in progress
  a_done_in_run: assert property (@(posedge clk) disable iff (reset_i)
    run_done_i |-> !idle_q);

endmodule

/* rtl/hsid_dist_unit.sv */
module hsid_dist_unit import hsid_pkg::*; #(
  parameter int MAX_BANDS = 64
) (
  input  logic        clk,
  input  logic        reset_i,
  input  fetch_word_t word_i,
  output dist_res_t   res_o
);

  localparam int DEPTH = MAX_BANDS / 2;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  pixel_word_t         capt_buf [DEPTH];  // Captured pixel, two bands per entry
  pixel_word_t         ref_word;
  logic [AW-1:0]       buf_idx;
  band_t               diff_hi;
  band_t               diff_lo;
  logic                s1_valid;
  logic                s1_first;
  logic                s1_last;
  logic                s1_last_pix;
  logic [PIX_W-1:0]    s1_pix;
  logic [2*BAND_W-1:0] sq_hi;
  logic [2*BAND_W-1:0] sq_lo;
  sse_t                acc_q;
  sse_t                acc_next;
  logic                res_valid_q;
  logic                res_last_q;
  logic [PIX_W-1:0]    res_pix_q;

  assign buf_idx  = word_i.tag.word_idx[AW-1:0];
  assign ref_word = capt_buf[buf_idx];

  // Absolute band differences keep the squares unsigned
  always_comb begin
    diff_hi = (word_i.data.bands.band_hi >= ref_word.bands.band_hi) ?
              word_i.data.bands.band_hi - ref_word.bands.band_hi :
              ref_word.bands.band_hi - word_i.data.bands.band_hi;
    diff_lo = (word_i.data.bands.band_lo >= ref_word.bands.band_lo) ?
              word_i.data.bands.band_lo - ref_word.bands.band_lo :
              ref_word.bands.band_lo - word_i.data.bands.band_lo;
  end

  always_ff @(posedge clk) begin
    if (word_i.valid && word_i.tag.is_capt) begin
      capt_buf[buf_idx] <= word_i.data;
    end
  end

  // Stage one squares, payload only
  always_ff @(posedge clk) begin
    sq_hi       <= 32'(diff_hi) * 32'(diff_hi);
    sq_lo       <= 32'(diff_lo) * 32'(diff_lo);
    s1_first    <= (word_i.tag.word_idx == '0);
    s1_last     <= word_i.tag.last_word;
    s1_last_pix <= word_i.tag.last_pix;
    s1_pix      <= word_i.tag.pix_idx;
  end

  assign acc_next = (s1_first ? '0 : acc_q) + SSE_W'(sq_hi) + SSE_W'(sq_lo);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      s1_valid    <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      s1_valid    <= word_i.valid && !word_i.tag.is_capt;
      res_valid_q <= s1_valid && s1_last;  // Sum is complete on the last word
    end
  end

  // Stage two accumulates, restarting on word zero
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      acc_q      <= acc_next;
      res_pix_q  <= s1_pix;
      res_last_q <= s1_last_pix;
    end
  end

  always_comb begin
    res_o.valid    = res_valid_q;
    res_o.pix_idx  = res_pix_q;
    res_o.value    = acc_q;
    res_o.last_pix = res_last_q;
  end

endmodule

/* rtl/hsid_extreme_trk.sv */
module hsid_extreme_trk import hsid_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      clear_i,
  input  dist_res_t res_i,
  output extremes_t extremes_o,
  output logic      run_done_o
);

  always_ff @(posedge clk) begin
    if (reset_i || clear_i) begin
      extremes_o.min_val <= '1;  // Any real distance beats this
      extremes_o.min_ref <= '0;
      extremes_o.max_val <= '0;
      extremes_o.max_ref <= '0;
    end else if (res_i.valid) begin
      // Strict compares so a tie keeps the earlier index
      if (res_i.value < extremes_o.min_val) begin
        extremes_o.min_val <= res_i.value;
        extremes_o.min_ref <= res_i.pix_idx;
      end
      if (res_i.value > extremes_o.max_val) begin
        extremes_o.max_val <= res_i.value;
        extremes_o.max_ref <= res_i.pix_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      run_done_o <= 1'b0;
    end else begin
      run_done_o <= res_i.valid && res_i.last_pix;  // One-cycle pulse
    end
  end

  // Results from the distance unit must be fully defined
  a_res_known: assert property (@(posedge clk) disable iff (reset_i)
    res_i.valid |-> !$isunknown(res_i));

endmodule

/* rtl/hsid_fetch_seq.sv */
module hsid_fetch_seq import hsid_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  cfg_t        cfg_i,
  input  logic        run_start_i,
  output mem_req_t    mem_req_o,
  input  pixel_word_t mem_rdata_i,
  output fetch_word_t word_o
);

  logic              busy_q;
  logic              capt_q;   // Still reading the captured pixel
  logic [WIDX_W-1:0] word_q;
  logic [PIX_W-1:0]  pix_q;
  logic [WORD_W-1:0] addr_q;
  logic              start_ok;
  logic              issue;
  logic [WIDX_W-1:0] wpp;      // Words per pixel
  word_tag_t         iss_tag;
  logic [WORD_W-1:0] iss_addr;
  logic              req_valid_q;
  logic [WORD_W-1:0] req_addr_q;
  word_tag_t         tag_q;
  word_tag_t         tag_d;
  logic              valid_d;

  assign wpp      = {1'b0, cfg_i.bands[7:1]};
  assign start_ok = run_start_i && !busy_q;
  assign issue    = start_ok || busy_q;

  // Describe the word that goes out this cycle
  always_comb begin
    iss_tag.is_capt   = start_ok || capt_q;
    iss_tag.word_idx  = start_ok ? '0 : word_q;
    iss_tag.pix_idx   = start_ok ? '0 : pix_q;
    iss_tag.last_word = (iss_tag.word_idx == wpp - 1'b1);
    iss_tag.last_pix  = !iss_tag.is_capt && iss_tag.last_word &&
                        (iss_tag.pix_idx == cfg_i.lib_size - 1'b1);
    iss_addr          = start_ok ? cfg_i.capt_addr : addr_q;
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      capt_q      <= 1'b0;
      word_q      <= '0;
      pix_q       <= '0;
      addr_q      <= '0;
      req_valid_q <= 1'b0;
      valid_d     <= 1'b0;
    end else begin
      req_valid_q <= issue;
      valid_d     <= req_valid_q;  // Data comes back one cycle after the strobe
      if (issue) begin
        busy_q <= 1'b1;
        capt_q <= iss_tag.is_capt;
        addr_q <= iss_addr + 1'b1;
        if (iss_tag.last_word) begin
          word_q <= '0;
          if (iss_tag.is_capt) begin
            capt_q <= 1'b0;  // Library follows at its own base
            pix_q  <= '0;
            addr_q <= cfg_i.lib_addr;
          end else if (iss_tag.last_pix) begin
            busy_q <= 1'b0;
          end else begin
            pix_q <= pix_q + 1'b1;
          end
        end else begin
          word_q <= iss_tag.word_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    req_addr_q <= iss_addr;
    tag_q      <= iss_tag;
    tag_d      <= tag_q;
  end

  always_comb begin
    mem_req_o.valid = req_valid_q;
    mem_req_o.addr  = req_addr_q;
    word_o.data     = mem_rdata_i;
    word_o.tag      = tag_d;
    word_o.valid    = valid_d;
  end

  // A new run never lands on one still issuing reads
  a_start_idle: assert property (@(posedge clk) disable iff (reset_i)
    run_start_i |-> !busy_q);

endmodule

/* rtl/hsid_pkg.sv */
package hsid_pkg;

  localparam int BAND_W = 16;
  localparam int WORD_W = 32;
  localparam int SSE_W  = 48;
  localparam int PIX_W  = 12;
  localparam int WIDX_W = 8;

  // Register indices
  localparam logic [3:0] REG_CTRL      = 4'd0;   // Bit 0 start, bit 1 clear
  localparam logic [3:0] REG_STATUS    = 4'd1;   // Bit 0 idle, bit 1 done, bit 2 error
  localparam logic [3:0] REG_BANDS     = 4'd2;
  localparam logic [3:0] REG_LIB_SIZE  = 4'd3;
  localparam logic [3:0] REG_CAPT_ADDR = 4'd4;
  localparam logic [3:0] REG_LIB_ADDR  = 4'd5;
  localparam logic [3:0] REG_MIN_LO    = 4'd6;
  localparam logic [3:0] REG_MIN_HI    = 4'd7;
  localparam logic [3:0] REG_MIN_REF   = 4'd8;
  localparam logic [3:0] REG_MAX_LO    = 4'd9;
  localparam logic [3:0] REG_MAX_HI    = 4'd10;
  localparam logic [3:0] REG_MAX_REF   = 4'd11;

  typedef logic [BAND_W-1:0] band_t;
  typedef logic [SSE_W-1:0]  sse_t;

  // One memory word, either raw or as two bands (lower band number in the low half)
  typedef union packed {
    logic [WORD_W-1:0] raw;
    struct packed {
      band_t band_hi;
      band_t band_lo;
    } bands;
  } pixel_word_t;

  typedef struct packed {
    logic              is_capt;
    logic [WIDX_W-1:0] word_idx;
    logic [PIX_W-1:0]  pix_idx;
    logic              last_word;
    logic              last_pix;
  } word_tag_t;

  typedef struct packed {
    pixel_word_t data;
    word_tag_t   tag;
    logic        valid;
  } fetch_word_t;

  typedef struct packed {
    logic             valid;
    logic [PIX_W-1:0] pix_idx;
    sse_t             value;
    logic             last_pix;
  } dist_res_t;

  typedef struct packed {
    logic [7:0]        bands;
    logic [PIX_W-1:0]  lib_size;
    logic [WORD_W-1:0] capt_addr;
    logic [WORD_W-1:0] lib_addr;
  } cfg_t;

  typedef struct packed {
    sse_t             min_val;
    logic [PIX_W-1:0] min_ref;
    sse_t             max_val;
    logic [PIX_W-1:0] max_ref;
  } extremes_t;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [3:0]        addr;
    logic [WORD_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] addr;  // Word address
  } mem_req_t;

endpackage

/* rtl/hsid_top.sv */
module hsid_top import hsid_pkg::*; #(
  parameter int MAX_BANDS = 64
) (
  input  logic        clk,
  input  logic        reset_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  output mem_req_t    mem_req_o,
  input  pixel_word_t mem_rdata_i,
  output logic        irq_o
);

  cfg_t        cfg;
  logic        run_start;
  logic        clear;
  logic        run_done;
  fetch_word_t fetch_word;
  dist_res_t   dist_res;
  extremes_t   extremes;

  assign irq_o = run_done;

  hsid_ctrl_reg #(
    .MAX_BANDS (MAX_BANDS)
  ) u_ctrl_reg (
    .clk         (clk),
    .reset_i     (reset_i),
    .reg_req_i   (reg_req_i),
    .reg_rsp_o   (reg_rsp_o),
    .extremes_i  (extremes),
    .run_done_i  (run_done),
    .cfg_o       (cfg),
    .run_start_o (run_start),
    .clear_o     (clear)
  );

  hsid_fetch_seq u_fetch_seq (
    .clk         (clk),
    .reset_i     (reset_i),
    .cfg_i       (cfg),
    .run_start_i (run_start),
    .mem_req_o   (mem_req_o),
    .mem_rdata_i (mem_rdata_i),
    .word_o      (fetch_word)
  );

  hsid_dist_unit #(
    .MAX_BANDS (MAX_BANDS)
  ) u_dist_unit (
    .clk     (clk),
    .reset_i (reset_i),
    .word_i  (fetch_word),
    .res_o   (dist_res)
  );

  hsid_extreme_trk u_extreme_trk (
    .clk        (clk),
    .reset_i    (reset_i),
    .clear_i    (clear),
    .res_i      (dist_res),
    .extremes_o (extremes),
    .run_done_o (run_done)
  );

endmodule
